// File: hdl/frontEnd_params.svh
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// raw fetch word, two 32-bit instructions
`define FETCH_W 64

// sequence numbers wrap at 128
`define SQN_W 7

// micro-ops handed out per dispatched bundle
`define DISPATCH_W 4

// free ROB slots needed before the front end may move
`define WINDOW_MARGIN 4

// memory controller fill port addressing
`define SRAM_ADDR_W 10
`define EXT_ADDR_W 30

`endif

// File: hdl/frontEndPkg.sv
`include "frontEnd_params.svh"

package frontEndPkg;

    // sequence number as handed out by rename and tracked by the ROB
    typedef logic [`SQN_W-1:0] sqN_t;

    // one fetch beat, two instructions side by side
    typedef logic [`FETCH_W-1:0] fetchWord_t;

    // how many of fetch, decode and rename hold a valid bundle
    typedef enum logic [1:0] {
        PIPE_EMPTY  = 2'd0,
        PIPE_FETCH  = 2'd1,
        PIPE_DECODE = 2'd2,
        PIPE_FULL   = 2'd3
    } fetchState_t;

    // fill request from one cache towards the memory controller
    typedef struct packed {
        logic                    ce;
        logic                    we;
        logic [`SRAM_ADDR_W-1:0] sramAddr;
        logic [`EXT_ADDR_W-1:0]  extAddr;
    } memCtrlReq_t;

    // winning request plus the owner tag
    // cacheId is 1 for the instruction cache, 0 for the data cache
    typedef struct packed {
        memCtrlReq_t req;
        logic        cacheId;
    } memCtrlPort_t;

endpackage

// File: hdl/fetchSequencer.sv
module fetchSequencer
    import frontEndPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic fetchEn,
    input  logic redirect,
    output logic instrReadEnable,
    output logic decodeValid
);

    fetchState_t state;
    fetchState_t stateNext;

    // one more stage fills per enabled cycle, saturating once rename is reached
    always_comb begin
        stateNext = state;
        if (redirect) begin
            stateNext = PIPE_EMPTY;
        end else if (fetchEn) begin
            case (state)
                PIPE_EMPTY:  stateNext = PIPE_FETCH;
                PIPE_FETCH:  stateNext = PIPE_DECODE;
                PIPE_DECODE: stateNext = PIPE_FULL;
                PIPE_FULL:   stateNext = PIPE_FULL;
                default:     stateNext = PIPE_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PIPE_EMPTY;
        end else begin
            state <= stateNext;
        end
    end

    // a word is consumed once the fetch stage holds a valid bundle
    assign instrReadEnable = (state != PIPE_EMPTY) && fetchEn;

    // bundle reaches rename only with all three stages valid
    assign decodeValid = (state == PIPE_FULL) && fetchEn;

endmodule

// File: hdl/seqWindowCounter.sv
`include "frontEnd_params.svh"

module seqWindowCounter
    import frontEndPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic redirect,
    input  logic decodeValid,
    input  sqN_t redirectSqN,
    input  sqN_t maxSqN,
    output sqN_t nextSqN,
    output logic dispatchEnable
);

    localparam int WindowLimit = -`WINDOW_MARGIN;

    // distance to the ROB limit, signed so the wrap at 127 is harmless
    logic signed [`SQN_W-1:0] sqNDiff;

    always_ff @(posedge clk) begin
        if (rst) begin
            nextSqN <= '0;
        end else if (redirect) begin
            // restart numbering right after the redirecting instruction
            nextSqN <= redirectSqN;
        end else if (decodeValid) begin
            nextSqN <= nextSqN + sqN_t'(`DISPATCH_W);
        end
    end

    assign sqNDiff = nextSqN - maxSqN;

    // need at least a full bundle of free ROB entries ahead of us
    assign dispatchEnable = en && !redirect && (sqNDiff <= WindowLimit);

endmodule

// File: hdl/instrHoldBuffer.sv
module instrHoldBuffer
    import frontEndPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       instrReadEnable,
    input  fetchWord_t instrRaw,
    output fetchWord_t fetchWord
);

    fetchWord_t heldWord;
    logic       useHeld;

    // the fetch bus moves on while reads are paused, so keep what was shown
    always_ff @(posedge clk) begin
        if (!instrReadEnable) begin
            heldWord <= fetchWord;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            useHeld <= 1'b0;
        end else begin
            useHeld <= !instrReadEnable;
        end
    end

    // replay the held word for one cycle after the pause
    assign fetchWord = useHeld ? heldWord : instrRaw;

endmodule

// File: hdl/fillPortArbiter.sv
module fillPortArbiter
    import frontEndPkg::*;
(
    input  memCtrlReq_t  icReq,
    input  memCtrlReq_t  dcReq,
    input  logic         mcBusy,
    output memCtrlPort_t mcPort,
    output logic         icBusy,
    output logic         dcBusy
);

    // instruction cache fills always win the shared port
    always_comb begin
        if (icReq.ce) begin
            mcPort.req     = icReq;
            mcPort.cacheId = 1'b1;
        end else begin
            mcPort.req     = dcReq;
            mcPort.cacheId = 1'b0;
        end
    end

    // each side sees the port busy while the other one requests
    assign icBusy = mcBusy || dcReq.ce;
    assign dcBusy = mcBusy || icReq.ce;

endmodule

// File: hdl/frontEnd.sv
module frontEnd
    import frontEndPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  logic         decodeFull,
    input  logic         redirect,
    input  logic         mcBusy,
    input  sqN_t         redirectSqN,
    input  sqN_t         maxSqN,
    input  fetchWord_t   instrRaw,
    input  memCtrlReq_t  icReq,
    input  memCtrlReq_t  dcReq,
    output logic         instrReadEnable,
    output logic         decodeValid,
    output logic         dispatchEnable,
    output logic         icBusy,
    output logic         dcBusy,
    output sqN_t         nextSqN,
    output fetchWord_t   fetchWord,
    output memCtrlPort_t mcPort
);

    logic fetchEn;

    // downstream space and an open ROB window both needed to move
    assign fetchEn = !decodeFull && dispatchEnable;

    fetchSequencer u_fetchSequencer (
        .clk             (clk),
        .rst             (rst),
        .fetchEn         (fetchEn),
        .redirect        (redirect),
        .instrReadEnable (instrReadEnable),
        .decodeValid     (decodeValid)
    );

    // sequence numbers advance once per bundle leaving decode
    seqWindowCounter u_seqWindowCounter (
        .clk            (clk),
        .rst            (rst),
        .en             (en),
        .redirect       (redirect),
        .decodeValid    (decodeValid),
        .redirectSqN    (redirectSqN),
        .maxSqN         (maxSqN),
        .nextSqN        (nextSqN),
        .dispatchEnable (dispatchEnable)
    );

    instrHoldBuffer u_instrHoldBuffer (
        .clk             (clk),
        .rst             (rst),
        .instrReadEnable (instrReadEnable),
        .instrRaw        (instrRaw),
        .fetchWord       (fetchWord)
    );

    fillPortArbiter u_fillPortArbiter (
        .icReq  (icReq),
        .dcReq  (dcReq),
        .mcBusy (mcBusy),
        .mcPort (mcPort),
        .icBusy (icBusy),
        .dcBusy (dcBusy)
    );

endmodule

// File: test/frontEndTb.sv
module frontEndTb
    import frontEndPkg::*;
#(
    parameter int unsigned Seed = 32'h2481_6e38
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam string CaseFile    = "test/frontEndCases.txt";
    localparam int    RandomCount = 200;
    localparam int    CycleMargin = 20;

    // one cycle of stimulus with its expected outputs
    typedef struct packed {
        logic       en;
        logic       decodeFull;
        logic       redirect;
        sqN_t       redirectSqN;
        sqN_t       maxSqN;
        fetchWord_t instrRaw;
        logic       expReadEnable;
        logic       expDecodeValid;
        logic       expDispatchEnable;
        sqN_t       expNextSqN;
        fetchWord_t expFetchWord;
    } caseLine_t;

    logic         clk;
    logic         rst;
    logic         en;
    logic         decodeFull;
    logic         redirect;
    logic         mcBusy;
    sqN_t         redirectSqN;
    sqN_t         maxSqN;
    fetchWord_t   instrRaw;
    memCtrlReq_t  icReq;
    memCtrlReq_t  dcReq;
    logic         instrReadEnable;
    logic         decodeValid;
    logic         dispatchEnable;
    logic         icBusy;
    logic         dcBusy;
    sqN_t         nextSqN;
    fetchWord_t   fetchWord;
    memCtrlPort_t mcPort;

    caseLine_t   cases[$];
    int          cycleCount = 0;
    int          cycleLimit = RandomCount + CycleMargin;

    frontEnd u_dut (
        .clk             (clk),
        .rst             (rst),
        .en              (en),
        .decodeFull      (decodeFull),
        .redirect        (redirect),
        .mcBusy          (mcBusy),
        .redirectSqN     (redirectSqN),
        .maxSqN          (maxSqN),
        .instrRaw        (instrRaw),
        .icReq           (icReq),
        .dcReq           (dcReq),
        .instrReadEnable (instrReadEnable),
        .decodeValid     (decodeValid),
        .dispatchEnable  (dispatchEnable),
        .icBusy          (icBusy),
        .dcBusy          (dcBusy),
        .nextSqN         (nextSqN),
        .fetchWord       (fetchWord),
        .mcPort          (mcPort)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            failRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic checkSqN(input sqN_t got, input sqN_t exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic checkWord(input fetchWord_t got, input fetchWord_t exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic checkPort(input memCtrlPort_t got, input memCtrlPort_t exp,
                             input string what);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    // lines starting with # are comments
    task automatic loadCases();
        int          fd;
        int          fieldCount;
        string       line;
        logic [63:0] field [11];
        caseLine_t   c;
        fd = $fopen(CaseFile, "r");
        if (fd == 0) begin
            failRun({"cannot open the case file ", CaseFile});
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fieldCount = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                field[0], field[1], field[2], field[3], field[4], field[5],
                field[6], field[7], field[8], field[9], field[10]);
            if (fieldCount != 11) begin
                failRun({"malformed line in the case file: ", line});
            end
            c.en                = field[0][0];
            c.decodeFull        = field[1][0];
            c.redirect          = field[2][0];
            c.redirectSqN       = sqN_t'(field[3]);
            c.maxSqN            = sqN_t'(field[4]);
            c.instrRaw          = fetchWord_t'(field[5]);
            c.expReadEnable     = field[6][0];
            c.expDecodeValid    = field[7][0];
            c.expDispatchEnable = field[8][0];
            c.expNextSqN        = sqN_t'(field[9]);
            c.expFetchWord      = fetchWord_t'(field[10]);
            cases.push_back(c);
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            failRun("the case file holds no cases");
        end
    endtask

    task automatic applyCase(input caseLine_t c);
        en          = c.en;
        decodeFull  = c.decodeFull;
        redirect    = c.redirect;
        redirectSqN = c.redirectSqN;
        maxSqN      = c.maxSqN;
        instrRaw    = c.instrRaw;
    endtask

    task automatic checkCase(input caseLine_t c, input int idx);
        checkBit(instrReadEnable, c.expReadEnable, $sformatf("case %0d instrReadEnable", idx));
        checkBit(decodeValid, c.expDecodeValid, $sformatf("case %0d decodeValid", idx));
        checkBit(dispatchEnable, c.expDispatchEnable,
            $sformatf("case %0d dispatchEnable", idx));
        checkSqN(nextSqN, c.expNextSqN, $sformatf("case %0d nextSqN", idx));
        checkWord(fetchWord, c.expFetchWord, $sformatf("case %0d fetchWord", idx));
    endtask

    function automatic memCtrlReq_t randomReq();
        logic [63:0] bits;
        bits = {$urandom(), $urandom()};
        return bits[$bits(memCtrlReq_t)-1:0];
    endfunction

    task automatic runArbiterCase(input int idx);
        memCtrlReq_t  ic;
        memCtrlReq_t  dc;
        logic [31:0]  busyBits;
        memCtrlPort_t expPort;
        ic       = randomReq();
        dc       = randomReq();
        busyBits = $urandom();
        icReq    = ic;
        dcReq    = dc;
        mcBusy   = busyBits[0];
        // instruction cache owns the port whenever it asks
        if (ic.ce) begin
            expPort.req     = ic;
            expPort.cacheId = 1'b1;
        end else begin
            expPort.req     = dc;
            expPort.cacheId = 1'b0;
        end
        #90;
        checkPort(mcPort, expPort, $sformatf("arbiter %0d mcPort", idx));
        checkBit(icBusy, busyBits[0] || dc.ce, $sformatf("arbiter %0d icBusy", idx));
        checkBit(dcBusy, busyBits[0] || ic.ce, $sformatf("arbiter %0d dcBusy", idx));
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        en          = 1'b0;
        decodeFull  = 1'b0;
        redirect    = 1'b0;
        mcBusy      = 1'b0;
        redirectSqN = '0;
        maxSqN      = '0;
        instrRaw    = '0;
        icReq       = '0;
        dcReq       = '0;
        void'($urandom(Seed));
        loadCases();
        cycleLimit = cases.size() + RandomCount + CycleMargin;

        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        // inputs change 5 ns after the edge, outputs checked 5 ns before the next
        foreach (cases[i]) begin
            applyCase(cases[i]);
            #90;
            checkCase(cases[i], i);
            @(posedge clk);
            #5;
        end

        for (int i = 0; i < RandomCount; i++) begin
            runArbiterCase(i);
            @(posedge clk);
            #5;
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/frontEndPkg.sv
hdl/fetchSequencer.sv
hdl/seqWindowCounter.sv
hdl/instrHoldBuffer.sv
hdl/fillPortArbiter.sv
hdl/frontEnd.sv
test/frontEndTb.sv

// File: Makefile
# Verilator build for the fetch front end testbench

TOP    ?= frontEndTb
SEED   ?= 612462136
BUILD  ?= obj_dir
FLIST  ?= flist.f
VFLAGS ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) -f $(FLIST) --top-module $(TOP) -GSeed=$(SEED) -Mdir $(BUILD)

# a failing run ends in $$fatal, which gives a nonzero exit status
run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: test/frontEndCases.txt
# in:  en decodeFull redirect redirectSqN maxSqN instrRaw
# exp: instrReadEnable decodeValid dispatchEnable nextSqN fetchWord (all hex, one line per cycle)
# fill after reset, then nextSqN steps by 4
1 0 0 00 20 cafe000000000000 0 0 1 00 cafe000000000000
1 0 0 00 20 cafe000000000001 1 0 1 00 cafe000000000000
1 0 0 00 20 cafe000000000002 1 0 1 00 cafe000000000002
1 0 0 00 20 cafe000000000003 1 1 1 00 cafe000000000003
1 0 0 00 20 cafe000000000004 1 1 1 04 cafe000000000004
1 0 0 00 20 cafe000000000005 1 1 1 08 cafe000000000005
1 0 0 00 20 cafe000000000006 1 1 1 0c cafe000000000006
# redirect to 05, pipeline refills
1 0 1 05 20 cafe000000000007 0 0 0 10 cafe000000000007
1 0 0 00 20 cafe000000000008 0 0 1 05 cafe000000000007
1 0 0 00 20 cafe000000000009 1 0 1 05 cafe000000000007
1 0 0 00 20 cafe00000000000a 1 0 1 05 cafe00000000000a
1 0 0 00 20 cafe00000000000b 1 1 1 05 cafe00000000000b
1 0 0 00 20 cafe00000000000c 1 1 1 09 cafe00000000000c
# run into the ROB window
1 0 0 00 20 cafe00000000000d 1 1 1 0d cafe00000000000d
1 0 0 00 20 cafe00000000000e 1 1 1 11 cafe00000000000e
1 0 0 00 20 cafe00000000000f 1 1 1 15 cafe00000000000f
1 0 0 00 20 cafe000000000010 1 1 1 19 cafe000000000010
1 0 0 00 20 cafe000000000011 0 0 0 1d cafe000000000011
1 0 0 00 20 cafe000000000012 0 0 0 1d cafe000000000011
1 0 0 00 21 cafe000000000013 1 1 1 1d cafe000000000011
1 0 0 00 21 cafe000000000014 0 0 0 21 cafe000000000014
# window across the wrap at 127
1 0 1 78 7e cafe000000000015 0 0 0 21 cafe000000000014
1 0 0 00 7e cafe000000000016 0 0 1 78 cafe000000000014
1 0 0 00 7e cafe000000000017 1 0 1 78 cafe000000000014
1 0 0 00 7e cafe000000000018 1 0 1 78 cafe000000000018
1 0 0 00 7e cafe000000000019 1 1 1 78 cafe000000000019
1 0 0 00 7e cafe00000000001a 0 0 0 7c cafe00000000001a
1 0 0 00 02 cafe00000000001b 1 1 1 7c cafe00000000001a
1 0 0 00 02 cafe00000000001c 0 0 0 00 cafe00000000001c
1 0 0 00 10 cafe00000000001d 1 1 1 00 cafe00000000001c
# decodeFull stalls reads, held word replayed after release
1 1 0 00 10 cafe00000000001e 0 0 1 04 cafe00000000001e
1 1 0 00 10 cafe00000000001f 0 0 1 04 cafe00000000001e
1 0 0 00 10 cafe000000000020 1 1 1 04 cafe00000000001e
1 0 0 00 10 cafe000000000021 1 1 1 08 cafe000000000021
# front end disabled
0 0 0 00 10 cafe000000000022 0 0 0 0c cafe000000000022
0 0 0 00 10 cafe000000000023 0 0 0 0c cafe000000000022
